/* src/axi_shim_pkg.sv */
// bus widths, width typedefs, axi burst/cache/response codes, write state enum
`default_nettype none

package axi_shim_pkg;

  //////////////////////////////////////////////////
  // bus widths
  //////////////////////////////////////////////////

  localparam int unsigned AddrW = 32;
  localparam int unsigned DataW = 64;
  localparam int unsigned IdW   = 4;
  // one strobe bit per data byte
  localparam int unsigned StrbW = DataW / 8;

  typedef logic [AddrW-1:0] addr_t;
  typedef logic [DataW-1:0] data_t;
  typedef logic [StrbW-1:0] strb_t;
  typedef logic [IdW-1:0]   id_t;

  // axi beat size, bytes = 2**size
  typedef logic [2:0] size_t;
  typedef logic [1:0] resp_t;

  //////////////////////////////////////////////////
  // axi encodings
  //////////////////////////////////////////////////

  // incrementing burst, the only kind issued
  localparam logic [1:0] BurstIncr = 2'b01;

  // normal non-cacheable but modifiable
  localparam logic [3:0] CacheModifiable = 4'b0010;

  localparam resp_t RespOkay   = 2'b00;
  // exclusive access succeeded
  localparam resp_t RespExokay = 2'b01;

  //////////////////////////////////////////////////
  // write channel fsm
  //////////////////////////////////////////////////

  // aw and w handshakes may finish in either order
  typedef enum logic [2:0] {
    Idle,
    WaitAw,
    WaitLastW,
    WaitLastWAw,
    WaitAwBurst
  } wr_state_e;

endpackage

`default_nettype wire

/* src/axi_beat_cnt.sv */
// axi_beat_cnt: index of the current write beat, with clear, enable and done flag
`timescale 1ns/1ps
`default_nettype none

module axi_beat_cnt #(
  parameter int unsigned NumWords  = 4,
  parameter bit          BurstWrEn = 1'b1
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 clr_i,
  input  logic                 en_i,
  input  logic [IdxW-1:0]      blen_i,
  output logic [IdxW-1:0]      idx_o,
  output logic                 done_o
);

  // at least one bit, even for single-word lines
  localparam int unsigned IdxW = (NumWords > 1) ? $clog2(NumWords) : 1;

  logic [IdxW-1:0] idx_d, idx_q;

  // clear wins over enable
  // single-write builds never move off beat 0
  always_comb begin
    idx_d = idx_q;
    if (clr_i) begin
      idx_d = '0;
    end else if (en_i && BurstWrEn) begin
      idx_d = idx_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      idx_q <= '0;
    end else begin
      idx_q <= idx_d;
    end
  end

  assign idx_o = idx_q;
  // blen is len-1, so equality marks the last beat
  assign done_o = (idx_q == blen_i);

endmodule

`default_nettype wire

/* src/axi_wr_fsm.sv */
// axi_wr_fsm: orders aw and w transfers, drives valids, write grant and beat counter controls
`timescale 1ns/1ps
`default_nettype none

module axi_wr_fsm import axi_shim_pkg::*; #(
  parameter int unsigned NumWords  = 4,
  parameter bit          BurstWrEn = 1'b1
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // requester
  input  logic                 wr_req_i,
  input  logic [IdxW-1:0]      wr_blen_i,
  output logic                 wr_gnt_o,
  // axi handshakes
  input  logic                 aw_ready_i,
  input  logic                 w_ready_i,
  output logic                 aw_valid_o,
  output logic                 w_valid_o,
  // beat counter
  input  logic                 cnt_done_i,
  output logic                 cnt_clr_o,
  output logic                 cnt_en_o
);

  localparam int unsigned IdxW = (NumWords > 1) ? $clog2(NumWords) : 1;

  wr_state_e state_d, state_q;
  logic      single;

  // len-1 of zero means one beat
  assign single = (wr_blen_i == '0);

  //////////////////////////////////////////////////
  // next state and outputs
  //////////////////////////////////////////////////

  always_comb begin
    state_d    = state_q;
    aw_valid_o = 1'b0;
    w_valid_o  = 1'b0;
    wr_gnt_o   = 1'b0;
    cnt_en_o   = 1'b0;

    case (state_q)
      Idle: begin
        if (wr_req_i && single) begin
          aw_valid_o = 1'b1;
          w_valid_o  = 1'b1;
          // both readies at once, done right here
          wr_gnt_o   = aw_ready_i & w_ready_i;
          case ({aw_ready_i, w_ready_i})
            2'b01:   state_d = WaitAw;
            2'b10:   state_d = WaitLastW;
            default: state_d = Idle;
          endcase
        end else if (wr_req_i && BurstWrEn) begin
          aw_valid_o = 1'b1;
          w_valid_o  = 1'b1;
          // first beat can go out with the address
          cnt_en_o   = w_ready_i;
          case ({aw_ready_i, w_ready_i})
            2'b11:   state_d = WaitLastW;
            2'b10:   state_d = WaitLastW;
            2'b01:   state_d = WaitLastWAw;
            default: state_d = Idle;
          endcase
        end
      end

      // single write, data taken, address pending
      WaitAw: begin
        aw_valid_o = 1'b1;
        if (aw_ready_i) begin
          wr_gnt_o = 1'b1;
          state_d  = Idle;
        end
      end

      // address taken, stream remaining beats
      WaitLastW: begin
        w_valid_o = 1'b1;
        if (w_ready_i) begin
          if (cnt_done_i) begin
            wr_gnt_o = 1'b1;
            state_d  = Idle;
          end else begin
            cnt_en_o = 1'b1;
          end
        end
      end

      // burst with address still pending, beats keep flowing
      WaitLastWAw: begin
        aw_valid_o = 1'b1;
        w_valid_o  = 1'b1;
        if (w_ready_i && cnt_done_i) begin
          if (aw_ready_i) begin
            wr_gnt_o = 1'b1;
            state_d  = Idle;
          end else begin
            // all data out, only the address left
            state_d = WaitAwBurst;
          end
        end else begin
          cnt_en_o = w_ready_i;
          if (aw_ready_i) begin
            state_d = WaitLastW;
          end
        end
      end

      // last beat gone, grant on the address
      WaitAwBurst: begin
        aw_valid_o = 1'b1;
        if (aw_ready_i) begin
          wr_gnt_o = 1'b1;
          state_d  = Idle;
        end
      end

      default: state_d = Idle;
    endcase
  end

  // beat index restarts with every grant
  assign cnt_clr_o = wr_gnt_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= Idle;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

`default_nettype wire

/* src/axi_wr_path.sv */
// axi_wr_path: aw fields, w beat select, b response decode and wack register
`timescale 1ns/1ps
`default_nettype none

module axi_wr_path import axi_shim_pkg::*; #(
  parameter int unsigned NumWords = 4,
  parameter bit          AceEn    = 1'b1
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // held write request
  input  addr_t                   wr_addr_i,
  input  data_t [NumWords-1:0]    wr_data_i,
  input  strb_t [NumWords-1:0]    wr_be_i,
  input  logic  [IdxW-1:0]        wr_blen_i,
  input  size_t                   wr_size_i,
  input  id_t                     wr_id_i,
  input  logic                    wr_lock_i,
  // beat counter
  input  logic  [IdxW-1:0]        beat_idx_i,
  input  logic                    cnt_done_i,
  // aw channel
  output addr_t                   aw_addr_o,
  output logic  [7:0]             aw_len_o,
  output size_t                   aw_size_o,
  output id_t                     aw_id_o,
  output logic                    aw_lock_o,
  output logic  [1:0]             aw_burst_o,
  output logic  [3:0]             aw_cache_o,
  // w channel
  output data_t                   w_data_o,
  output strb_t                   w_strb_o,
  output logic                    w_last_o,
  // b channel
  input  logic                    b_valid_i,
  input  id_t                     b_id_i,
  input  resp_t                   b_resp_i,
  output logic                    b_ready_o,
  // write response to requester
  input  logic                    wr_rdy_i,
  output logic                    wr_valid_o,
  output id_t                     wr_id_o,
  output logic                    wr_exokay_o,
  // ace
  output logic                    wack_o
);

  localparam int unsigned IdxW = (NumWords > 1) ? $clog2(NumWords) : 1;

  logic wack_d, wack_q;

  // address channel straight from the held request
  assign aw_addr_o  = wr_addr_i;
  assign aw_len_o   = 8'(wr_blen_i);
  assign aw_size_o  = wr_size_i;
  assign aw_id_o    = wr_id_i;
  assign aw_lock_o  = wr_lock_i;
  assign aw_burst_o = BurstIncr;
  assign aw_cache_o = CacheModifiable;

  // current beat of the line
  assign w_data_o = wr_data_i[beat_idx_i];
  assign w_strb_o = wr_be_i[beat_idx_i];
  assign w_last_o = cnt_done_i;

  // b passes through, requester sinks it
  assign b_ready_o   = wr_rdy_i;
  assign wr_valid_o  = b_valid_i;
  assign wr_id_o     = b_id_i;
  assign wr_exokay_o = (b_resp_i == RespExokay);

  //////////////////////////////////////////////////
  // ace write acknowledge
  //////////////////////////////////////////////////

  // one cycle after the b handshake
  assign wack_d = AceEn && b_valid_i && wr_rdy_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wack_q <= 1'b0;
    end else begin
      wack_q <= wack_d;
    end
  end

  assign wack_o = wack_q;

endmodule

`default_nettype wire

/* src/axi_rd_path.sv */
// axi_rd_path: read request onto ar, r back to requester, exokay decode and rack register
`timescale 1ns/1ps
`default_nettype none

module axi_rd_path import axi_shim_pkg::*; #(
  parameter int unsigned NumWords = 4,
  parameter bit          AceEn    = 1'b1
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  // read request
  input  logic              rd_req_i,
  input  addr_t             rd_addr_i,
  input  logic [IdxW-1:0]   rd_blen_i,
  input  size_t             rd_size_i,
  input  id_t               rd_id_i,
  input  logic              rd_lock_i,
  output logic              rd_gnt_o,
  // ar channel
  output logic              ar_valid_o,
  input  logic              ar_ready_i,
  output addr_t             ar_addr_o,
  output logic [7:0]        ar_len_o,
  output size_t             ar_size_o,
  output id_t               ar_id_o,
  output logic              ar_lock_o,
  output logic [1:0]        ar_burst_o,
  output logic [3:0]        ar_cache_o,
  // r channel
  input  logic              r_valid_i,
  input  data_t             r_data_i,
  input  logic              r_last_i,
  input  id_t               r_id_i,
  input  resp_t             r_resp_i,
  output logic              r_ready_o,
  // read data to requester
  input  logic              rd_rdy_i,
  output logic              rd_valid_o,
  output data_t             rd_data_o,
  output logic              rd_last_o,
  output id_t               rd_id_o,
  output logic              rd_exokay_o,
  // ace
  output logic              rack_o
);

  localparam int unsigned IdxW = (NumWords > 1) ? $clog2(NumWords) : 1;

  logic rack_d, rack_q;

  // request level is the ar valid
  assign ar_valid_o = rd_req_i;
  assign rd_gnt_o   = rd_req_i & ar_ready_i;
  assign ar_addr_o  = rd_addr_i;
  assign ar_len_o   = 8'(rd_blen_i);
  assign ar_size_o  = rd_size_i;
  assign ar_id_o    = rd_id_i;
  assign ar_lock_o  = rd_lock_i;
  assign ar_burst_o = BurstIncr;
  assign ar_cache_o = CacheModifiable;

  // return path, no storage
  assign r_ready_o   = rd_rdy_i;
  assign rd_valid_o  = r_valid_i;
  assign rd_data_o   = r_data_i;
  assign rd_last_o   = r_last_i;
  assign rd_id_o     = r_id_i;
  assign rd_exokay_o = (r_resp_i == RespExokay);

  //////////////////////////////////////////////////
  // ace read acknowledge
  //////////////////////////////////////////////////

  // after the last beat of a burst only
  assign rack_d = AceEn && r_valid_i && rd_rdy_i && r_last_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rack_q <= 1'b0;
    end else begin
      rack_q <= rack_d;
    end
  end

  assign rack_o = rack_q;

endmodule

`default_nettype wire

/* src/axi_shim.sv */
// axi_shim: top level, write fsm, beat counter, write path and read path
`timescale 1ns/1ps
`default_nettype none

module axi_shim import axi_shim_pkg::*; #(
  parameter int unsigned NumWords  = 4,
  parameter bit          BurstWrEn = 1'b1,
  parameter bit          AceEn     = 1'b1
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // write request
  input  logic                    wr_req_i,
  output logic                    wr_gnt_o,
  input  addr_t                   wr_addr_i,
  input  data_t [NumWords-1:0]    wr_data_i,
  input  strb_t [NumWords-1:0]    wr_be_i,
  input  logic  [IdxW-1:0]        wr_blen_i,
  input  size_t                   wr_size_i,
  input  id_t                     wr_id_i,
  input  logic                    wr_lock_i,
  // write response
  input  logic                    wr_rdy_i,
  output logic                    wr_valid_o,
  output id_t                     wr_id_o,
  output logic                    wr_exokay_o,
  // read request
  input  logic                    rd_req_i,
  output logic                    rd_gnt_o,
  input  addr_t                   rd_addr_i,
  input  logic  [IdxW-1:0]        rd_blen_i,
  input  size_t                   rd_size_i,
  input  id_t                     rd_id_i,
  input  logic                    rd_lock_i,
  // read data
  input  logic                    rd_rdy_i,
  output logic                    rd_valid_o,
  output data_t                   rd_data_o,
  output logic                    rd_last_o,
  output id_t                     rd_id_o,
  output logic                    rd_exokay_o,
  // axi aw
  output logic                    aw_valid_o,
  input  logic                    aw_ready_i,
  output addr_t                   aw_addr_o,
  output logic  [7:0]             aw_len_o,
  output size_t                   aw_size_o,
  output id_t                     aw_id_o,
  output logic                    aw_lock_o,
  output logic  [1:0]             aw_burst_o,
  output logic  [3:0]             aw_cache_o,
  // axi w
  output logic                    w_valid_o,
  input  logic                    w_ready_i,
  output data_t                   w_data_o,
  output strb_t                   w_strb_o,
  output logic                    w_last_o,
  // axi b
  input  logic                    b_valid_i,
  output logic                    b_ready_o,
  input  id_t                     b_id_i,
  input  resp_t                   b_resp_i,
  // axi ar
  output logic                    ar_valid_o,
  input  logic                    ar_ready_i,
  output addr_t                   ar_addr_o,
  output logic  [7:0]             ar_len_o,
  output size_t                   ar_size_o,
  output id_t                     ar_id_o,
  output logic                    ar_lock_o,
  output logic  [1:0]             ar_burst_o,
  output logic  [3:0]             ar_cache_o,
  // axi r
  input  logic                    r_valid_i,
  output logic                    r_ready_o,
  input  data_t                   r_data_i,
  input  logic                    r_last_i,
  input  id_t                     r_id_i,
  input  resp_t                   r_resp_i,
  // ace acknowledges
  output logic                    wack_o,
  output logic                    rack_o
);

  localparam int unsigned IdxW = (NumWords > 1) ? $clog2(NumWords) : 1;

  // fsm to counter
  logic            cnt_clr;
  logic            cnt_en;
  // counter to fsm and data select
  logic [IdxW-1:0] beat_idx;
  logic            cnt_done;

  //////////////////////////////////////////////////
  // write side
  //////////////////////////////////////////////////

  axi_wr_fsm #(
    .NumWords  (NumWords),
    .BurstWrEn (BurstWrEn)
  ) wr_fsm_i (
    .cnt_done_i (cnt_done),
    .cnt_clr_o  (cnt_clr),
    .cnt_en_o   (cnt_en),
    .*
  );

  axi_beat_cnt #(
    .NumWords  (NumWords),
    .BurstWrEn (BurstWrEn)
  ) beat_cnt_i (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .clr_i  (cnt_clr),
    .en_i   (cnt_en),
    .blen_i (wr_blen_i),
    .idx_o  (beat_idx),
    .done_o (cnt_done)
  );

  axi_wr_path #(
    .NumWords (NumWords),
    .AceEn    (AceEn)
  ) wr_path_i (
    .beat_idx_i (beat_idx),
    .cnt_done_i (cnt_done),
    .*
  );

  //////////////////////////////////////////////////
  // read side
  //////////////////////////////////////////////////

  axi_rd_path #(
    .NumWords (NumWords),
    .AceEn    (AceEn)
  ) rd_path_i (
    .*
  );

endmodule

`default_nettype wire

/* testbench/axi_shim_assert.sv */
// concurrent checks on the axi shim top level, attached with bind
`timescale 1ns/1ps
`default_nettype none

module axi_shim_assert import axi_shim_pkg::*; #(
  parameter int unsigned NumWords = 4,
  localparam int unsigned IdxW = (NumWords > 1) ? $clog2(NumWords) : 1
) (
  input logic clk_i, rst_ni,
  input logic wr_req_i, wr_gnt_o, wr_lock_i, wr_rdy_i,
  input addr_t wr_addr_i, aw_addr_o,
  input data_t [NumWords-1:0] wr_data_i,
  input strb_t [NumWords-1:0] wr_be_i,
  input logic [IdxW-1:0] wr_blen_i, rd_blen_i,
  input size_t wr_size_i, aw_size_o, rd_size_i, ar_size_o,
  input logic aw_valid_o, aw_ready_i, aw_lock_o, w_valid_o, w_ready_i, w_last_o,
  input logic [7:0] aw_len_o, ar_len_o,
  input logic [1:0] aw_burst_o, ar_burst_o,
  input logic [3:0] aw_cache_o, ar_cache_o,
  input data_t w_data_o, r_data_i, rd_data_o,
  input strb_t w_strb_o,
  input logic b_valid_i, b_ready_o, wr_valid_o, wr_exokay_o,
  input id_t wr_id_i, aw_id_o, b_id_i, wr_id_o, rd_id_i, ar_id_o, r_id_i, rd_id_o,
  input resp_t b_resp_i, r_resp_i,
  input logic rd_req_i, rd_gnt_o, rd_lock_i, ar_valid_o, ar_ready_i, ar_lock_o,
  input addr_t rd_addr_i, ar_addr_o,
  input logic rd_rdy_i, r_valid_i, r_ready_o, r_last_i,
  input logic rd_valid_o, rd_last_o, rd_exokay_o,
  input logic wack_o, rack_o
);

  // count of W transfers in the current write and whether its AW went out
  logic [IdxW:0] w_cnt;
  logic          aw_seen;
  logic          aw_now, w_now, w_all;

  assign aw_now = aw_valid_o & aw_ready_i;
  assign w_now  = w_valid_o & w_ready_i;
  assign w_all  = ((w_cnt + w_now) == ({1'b0, wr_blen_i} + 1'b1));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      w_cnt   <= '0;
      aw_seen <= 1'b0;
    end else if (wr_gnt_o) begin
      w_cnt   <= '0;
      aw_seen <= 1'b0;
    end else begin
      w_cnt   <= w_cnt + w_now;
      aw_seen <= aw_seen | aw_now;
    end
  end

  ////////////////////////////////////////////////
  // reset and write channel
  ////////////////////////////////////////////////

  a_reset_low: assert property (@(posedge clk_i)
    !rst_ni |-> !(aw_valid_o || w_valid_o || wr_gnt_o || wack_o || rack_o))
    else $error("outputs not low during reset");

  a_aw_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    aw_valid_o && !aw_ready_i |=> aw_valid_o) else $error("aw_valid dropped before handshake");
  a_w_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    w_valid_o && !w_ready_i |=> w_valid_o) else $error("w_valid dropped before handshake");
  a_valid_together: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(aw_valid_o) || $rose(w_valid_o) |-> aw_valid_o && w_valid_o)
    else $error("aw_valid and w_valid did not rise together");

  // address channel offered only for a held request
  a_aw_fields: assert property (@(posedge clk_i) disable iff (!rst_ni)
    aw_valid_o |-> wr_req_i && aw_addr_o == wr_addr_i && aw_len_o == 8'(wr_blen_i)
    && aw_size_o == wr_size_i && aw_id_o == wr_id_i && aw_lock_o == wr_lock_i
    && aw_burst_o == BurstIncr && aw_cache_o == CacheModifiable)
    else $error("AW fields differ from request");

  // n-th beat carries word n with last only on beat blen
  a_w_beat: assert property (@(posedge clk_i) disable iff (!rst_ni)
    w_now |-> w_data_o == wr_data_i[w_cnt[IdxW-1:0]] && w_strb_o == wr_be_i[w_cnt[IdxW-1:0]]
              && w_last_o == (w_cnt == {1'b0, wr_blen_i}))
    else $error("wrong W beat data, strobe or last");

  // grant exactly when the later of AW and last W completes
  a_wr_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wr_gnt_o == ((aw_seen || aw_now) && w_all && (aw_now || w_now)))
    else $error("write grant at the wrong cycle");

  ////////////////////////////////////////////////
  // read channel and responses
  ////////////////////////////////////////////////

  a_ar: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ar_valid_o == rd_req_i && rd_gnt_o == (rd_req_i && ar_ready_i))
    else $error("AR handshake does not follow read request");
  a_ar_fields: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rd_req_i |-> ar_addr_o == rd_addr_i && ar_len_o == 8'(rd_blen_i)
    && ar_size_o == rd_size_i && ar_id_o == rd_id_i && ar_lock_o == rd_lock_i
    && ar_burst_o == BurstIncr && ar_cache_o == CacheModifiable)
    else $error("AR fields differ from request");
  a_r: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rd_valid_o == r_valid_i && rd_data_o == r_data_i && rd_last_o == r_last_i
    && rd_id_o == r_id_i && rd_exokay_o == (r_resp_i == RespExokay))
    else $error("read data does not follow R");
  a_b: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wr_valid_o == b_valid_i && wr_id_o == b_id_i && wr_exokay_o == (b_resp_i == RespExokay))
    else $error("write response does not follow B");

  // requester readies are the channel readies
  a_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
    b_ready_o == wr_rdy_i && r_ready_o == rd_rdy_i)
    else $error("b_ready or r_ready differs from requester ready");

  a_wack: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wack_o == $past(b_valid_i && b_ready_o)) else $error("wack not one cycle after B");
  a_rack: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rack_o == $past(r_valid_i && r_ready_o && r_last_i))
    else $error("rack not one cycle after last R");

endmodule

bind axi_shim axi_shim_assert #(.NumWords(NumWords)) assert_i (.*);

`default_nettype wire

/* testbench/axi_shim_tb.sv */
// testbench for the axi shim: clock, reset, requester stimulus, axi responder, report
`timescale 1ns/1ps
`default_nettype none

module axi_shim_tb import axi_shim_pkg::*;;

  localparam int unsigned NumWords   = 4;
  localparam int unsigned IdxW       = $clog2(NumWords);
  localparam int          NumSingle  = 8;
  localparam int          NumBurst   = 8;
  localparam int          NumRead    = 8;
  // upper bound with bursts and reads counted at full length
  localparam int          TotalBeats = NumSingle + (NumBurst + NumRead) * NumWords;
  localparam int          MaxCycles  = 20 * TotalBeats + 200;

  logic clk_i = 1'b0, rst_ni;
  logic wr_req_i, wr_gnt_o, wr_lock_i, wr_rdy_i, wr_valid_o, wr_exokay_o;
  addr_t wr_addr_i, rd_addr_i, aw_addr_o, ar_addr_o;
  data_t [NumWords-1:0] wr_data_i;
  strb_t [NumWords-1:0] wr_be_i;
  logic [IdxW-1:0] wr_blen_i, rd_blen_i;
  size_t wr_size_i, rd_size_i, aw_size_o, ar_size_o;
  id_t wr_id_i, wr_id_o, rd_id_i, rd_id_o, aw_id_o, ar_id_o, b_id_i, r_id_i;
  logic rd_req_i, rd_gnt_o, rd_lock_i, rd_rdy_i, rd_valid_o, rd_last_o, rd_exokay_o;
  data_t rd_data_o, w_data_o, r_data_i;
  logic aw_valid_o, aw_ready_i, aw_lock_o, ar_valid_o, ar_ready_i, ar_lock_o;
  logic [7:0] aw_len_o, ar_len_o;
  logic [1:0] aw_burst_o, ar_burst_o;
  logic [3:0] aw_cache_o, ar_cache_o;
  logic w_valid_o, w_ready_i, w_last_o, b_valid_i, b_ready_o, r_valid_i, r_ready_o, r_last_i;
  strb_t w_strb_o;
  resp_t b_resp_i, r_resp_i;
  logic wack_o, rack_o;

  integer seed = 36;
  int     errors = 0;
  int     tests = 0;
  int     cycles = 0;

  // responder bookkeeping
  id_t   aw_id_q[$];
  int    w_bursts = 0;
  addr_t ar_addr_q[$];
  int    ar_len_q[$];
  id_t   ar_id_q[$];
  int    r_beat = 0;
  bit    b_flip = 1'b0;
  bit    r_flip = 1'b0;

  axi_shim #(.NumWords(NumWords)) dut_i (.*);

  always #20 clk_i = ~clk_i;

  // read beat pattern from address and beat number
  function automatic data_t pattern_word(addr_t addr, int beat);
    return {addr, 32'(beat) ^ 32'ha5a5_0000};
  endfunction

  task automatic check_val(string name, logic [63:0] got, logic [63:0] exp);
    if (got !== exp) begin
      $display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic report_test(string what, int err_before);
    tests++;
    $display("test %0d %s: %s", tests, what, (errors == err_before) ? "ok" : "errors");
  endtask

  // outputs that must sit low in and right after reset
  task automatic expect_reset_state();
    check_val("aw_valid_o", 64'(aw_valid_o), 64'd0);
    check_val("w_valid_o", 64'(w_valid_o), 64'd0);
    check_val("wr_gnt_o", 64'(wr_gnt_o), 64'd0);
    check_val("wack_o", 64'(wack_o), 64'd0);
    check_val("rack_o", 64'(rack_o), 64'd0);
  endtask

  ////////////////////////////////////////////////
  // axi responder with random stalls
  ////////////////////////////////////////////////

  always @(posedge clk_i) begin
    if (rst_ni) begin
      aw_ready_i <= ($random(seed) & 3) != 0;
      w_ready_i  <= ($random(seed) & 3) != 0;
      ar_ready_i <= ($random(seed) & 3) != 0;
      wr_rdy_i   <= ($random(seed) & 3) != 0;
      rd_rdy_i   <= ($random(seed) & 3) != 0;
      if (aw_valid_o && aw_ready_i) aw_id_q.push_back(aw_id_o);
      if (w_valid_o && w_ready_i && w_last_o) w_bursts++;
      if (ar_valid_o && ar_ready_i) begin
        ar_addr_q.push_back(ar_addr_o);
        ar_len_q.push_back(int'(ar_len_o));
        ar_id_q.push_back(ar_id_o);
      end
      // one B per write once both its AW and last W are in
      if (b_valid_i && b_ready_o) begin
        b_valid_i <= 1'b0;
      end else if (!b_valid_i && aw_id_q.size() > 0 && w_bursts > 0) begin
        b_valid_i <= 1'b1;
        b_id_i    <= aw_id_q.pop_front();
        // okay and exokay in turn
        b_resp_i  <= b_flip ? RespExokay : RespOkay;
        b_flip = !b_flip;
        w_bursts--;
      end
      // blen+1 R beats per AR
      if (r_valid_i && r_ready_o) begin
        if (r_last_i) begin
          r_valid_i <= 1'b0;
          r_beat = 0;
          void'(ar_addr_q.pop_front());
          void'(ar_len_q.pop_front());
          void'(ar_id_q.pop_front());
        end else begin
          r_beat++;
          r_data_i <= pattern_word(ar_addr_q[0], r_beat);
          r_last_i <= (r_beat == ar_len_q[0]);
        end
      end else if (!r_valid_i && ar_addr_q.size() > 0 && ($random(seed) & 1)) begin
        r_valid_i <= 1'b1;
        r_data_i  <= pattern_word(ar_addr_q[0], 0);
        r_last_i  <= (ar_len_q[0] == 0);
        r_id_i    <= ar_id_q[0];
        r_resp_i  <= r_flip ? RespExokay : RespOkay;
        r_flip = !r_flip;
      end
    end
  end

  // run limit
  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= MaxCycles) begin
      $display("timeout after %0d cycles, a handshake never completed", cycles);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  ////////////////////////////////////////////////
  // requester tasks
  ////////////////////////////////////////////////

  task automatic write_request(int blen, string what);
    int  err_before;
    id_t id;
    err_before = errors;
    id = id_t'($random(seed));
    @(posedge clk_i);
    wr_req_i  <= 1'b1;
    wr_addr_i <= addr_t'($random(seed)) & ~addr_t'(7);
    wr_blen_i <= IdxW'(blen);
    wr_id_i   <= id;
    wr_lock_i <= $random(seed) & 1;
    for (int i = 0; i < NumWords; i++) begin
      wr_data_i[i] <= {$random(seed), $random(seed)};
      wr_be_i[i]   <= strb_t'($random(seed));
    end
    do @(negedge clk_i); while (!wr_gnt_o);
    @(posedge clk_i);
    wr_req_i <= 1'b0;
    // the B for this write comes after its grant
    do @(negedge clk_i); while (!(wr_valid_o && wr_rdy_i));
    check_val("wr_id_o", 64'(wr_id_o), 64'(id));
    @(posedge clk_i);
    report_test(what, err_before);
  endtask

  task automatic read_burst(int blen);
    int    err_before;
    int    beat;
    id_t   id;
    addr_t addr;
    err_before = errors;
    beat = 0;
    id   = id_t'($random(seed));
    addr = addr_t'($random(seed)) & ~addr_t'(7);
    @(posedge clk_i);
    rd_req_i  <= 1'b1;
    rd_addr_i <= addr;
    rd_blen_i <= IdxW'(blen);
    rd_id_i   <= id;
    rd_lock_i <= $random(seed) & 1;
    do @(negedge clk_i); while (!rd_gnt_o);
    @(posedge clk_i);
    rd_req_i <= 1'b0;
    forever begin
      @(negedge clk_i);
      if (rd_valid_o && rd_rdy_i) begin
        check_val("rd_data_o", rd_data_o, pattern_word(addr, beat));
        check_val("rd_id_o", 64'(rd_id_o), 64'(id));
        check_val("rd_last_o", 64'(rd_last_o), 64'(beat == blen));
        if (rd_last_o) break;
        beat++;
      end
    end
    @(posedge clk_i);
    report_test("read", err_before);
  endtask

  initial begin
    int err_before;
    rst_ni = 1'b0;
    {wr_req_i, wr_lock_i, wr_rdy_i, rd_req_i, rd_lock_i, rd_rdy_i} = '0;
    {wr_addr_i, rd_addr_i, wr_data_i, wr_be_i, wr_blen_i, rd_blen_i} = '0;
    {wr_size_i, rd_size_i, wr_id_i, rd_id_i} = {3'd3, 3'd3, 8'h0};
    {aw_ready_i, w_ready_i, ar_ready_i, b_valid_i, r_valid_i, r_last_i} = '0;
    {b_id_i, b_resp_i, r_id_i, r_resp_i, r_data_i} = '0;
    err_before = errors;
    repeat (9) @(posedge clk_i);
    @(negedge clk_i);
    expect_reset_state();
    @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    expect_reset_state();
    @(posedge clk_i);
    report_test("reset", err_before);
    for (int i = 0; i < NumSingle; i++) write_request(0, "single write");
    for (int i = 0; i < NumBurst; i++) begin
      write_request(($unsigned($random(seed)) % (NumWords - 1)) + 1, "burst write");
    end
    for (int i = 0; i < NumRead; i++) read_burst($unsigned($random(seed)) % NumWords);
    repeat (4) @(posedge clk_i);
    $display("%0d tests run, %0d errors", tests, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
src/axi_shim_pkg.sv
src/axi_beat_cnt.sv
src/axi_wr_fsm.sv
src/axi_wr_path.sv
src/axi_rd_path.sv
src/axi_shim.sv
testbench/axi_shim_assert.sv
testbench/axi_shim_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the axi shim testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f src.f \
  --top-module axi_shim_tb -Mdir obj_dir -o axi_shim_sim > build.log 2>&1 \
  && ./obj_dir/axi_shim_sim > sim.log 2>&1 \
  || echo "Simulation finished: FAIL" >> sim.log

cat sim.log
grep -q "Simulation finished: FAIL" sim.log && exit 1 || exit 0
